/* include/pe_macros.svh */
`ifndef PE_MACROS_SVH
`define PE_MACROS_SVH

// Bus widths
`define PE_ADDR_W 32
`define PE_DATA_W 32

// Address field that picks a region, and the offset below it
`define PE_REGION_MSB 31
`define PE_REGION_LSB 24
`define PE_OFFSET_W   24

// Region codes
`define PE_REGION_DMEM 8'h01
`define PE_REGION_RTC  8'h02
`define PE_REGION_PLIC 8'h04
`define PE_REGION_NI   8'h08

// Real-time clock registers
`define PE_RTC_MTIME_LO 24'h00_0000
`define PE_RTC_MTIME_HI 24'h00_0004
`define PE_RTC_CMP_LO   24'h00_0008
`define PE_RTC_CMP_HI   24'h00_000C

// Interrupt controller registers
`define PE_PLIC_ENABLE   24'h00_0000
`define PE_PLIC_PENDING  24'h00_0004
`define PE_PLIC_COMPLETE 24'h00_0008

// Core interrupt vector positions
`define PE_MTI_BIT 7
`define PE_MEI_BIT 11

`endif

/* verilog/pe_pkg.sv */
`include "pe_macros.svh"

package pe_pkg;

    ////////////////////////////////////////
    // Basic words
    ////////////////////////////////////////

    typedef logic [`PE_DATA_W-1:0]   word_t;
    typedef logic [`PE_DATA_W-1:0]   irq_vec_t;
    typedef logic [2*`PE_DATA_W-1:0] mtime_t;

    ////////////////////////////////////////
    // Bus structs
    ////////////////////////////////////////

    // Request as issued by the core
    typedef struct packed {
        logic                   en;
        logic [`PE_DATA_W/8-1:0] be;
        logic [`PE_ADDR_W-1:0]  addr;
        word_t                  wdata;
    } bus_req_t;

    // Request seen by one peripheral, word writes only
    typedef struct packed {
        logic                   en;
        logic                   we;
        logic [`PE_OFFSET_W-1:0] offset;
        word_t                  wdata;
    } periph_req_t;

    // One-hot region select, all zero when unmapped
    typedef struct packed {
        logic dmem;
        logic rtc;
        logic plic;
        logic ni;
    } periph_sel_t;

endpackage

/* verilog/pe_rtc.sv */
`timescale 1ns/1ps

`include "pe_macros.svh"

module pe_rtc (
    input  logic                clk_i,
    input  logic                rst_ni,

    input  pe_pkg::periph_req_t req_i,
    output pe_pkg::word_t       rdata_o,

    output logic                mti_o,
    output pe_pkg::mtime_t      mtime_o
);

    import pe_pkg::*;

    mtime_t mtime_q;
    mtime_t mtimecmp_q;
    word_t  rd_word;
    word_t  rdata_q;

    logic   wr_en;
    logic   rd_en;

    assign wr_en = req_i.en && req_i.we;
    assign rd_en = req_i.en && !req_i.we;

    ////////////////////////////////////////
    // Time count and compare
    ////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mtime_q <= '0;
        end else begin
            mtime_q <= mtime_q + 1'b1;
        end
    end

    // Halves written one at a time, all ones keeps the timer quiet
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mtimecmp_q <= '1;
        end else if (wr_en) begin
            case (req_i.offset)
                `PE_RTC_CMP_LO: mtimecmp_q[`PE_DATA_W-1:0]           <= req_i.wdata;
                `PE_RTC_CMP_HI: mtimecmp_q[2*`PE_DATA_W-1:`PE_DATA_W] <= req_i.wdata;
                default: ;
            endcase
        end
    end

    assign mti_o   = (mtime_q >= mtimecmp_q);
    assign mtime_o = mtime_q;

    ////////////////////////////////////////
    // Read port
    ////////////////////////////////////////

    always_comb begin
        case (req_i.offset)
            `PE_RTC_MTIME_LO: rd_word = mtime_q[`PE_DATA_W-1:0];
            `PE_RTC_MTIME_HI: rd_word = mtime_q[2*`PE_DATA_W-1:`PE_DATA_W];
            `PE_RTC_CMP_LO:   rd_word = mtimecmp_q[`PE_DATA_W-1:0];
            `PE_RTC_CMP_HI:   rd_word = mtimecmp_q[2*`PE_DATA_W-1:`PE_DATA_W];
            default:          rd_word = '0;
        endcase
    end

    // Captured at the request edge, so the core sees it one cycle later
    always_ff @(posedge clk_i) begin
        if (rd_en) begin
            rdata_q <= rd_word;
        end
    end

    assign rdata_o = rdata_q;

endmodule

/* verilog/pe_plic.sv */
`timescale 1ns/1ps

`include "pe_macros.svh"

module pe_plic (
    input  logic                clk_i,
    input  logic                rst_ni,

    input  pe_pkg::periph_req_t req_i,
    input  logic                irq_src_i,

    output pe_pkg::word_t       rdata_o,
    output logic                mei_o
);

    import pe_pkg::*;

    logic  enable_q;
    logic  pending_q;
    logic  wr_en;
    logic  rd_en;
    logic  complete_wr;
    word_t rd_word;
    word_t rdata_q;

    assign wr_en       = req_i.en && req_i.we;
    assign rd_en       = req_i.en && !req_i.we;
    assign complete_wr = wr_en && (req_i.offset == `PE_PLIC_COMPLETE);

    ////////////////////////////////////////
    // Enable and pending
    ////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            enable_q <= 1'b0;
        end else if (wr_en && (req_i.offset == `PE_PLIC_ENABLE)) begin
            enable_q <= req_i.wdata[0];
        end
    end

    // A source still high wins over completion
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pending_q <= 1'b0;
        end else if (irq_src_i) begin
            pending_q <= 1'b1;
        end else if (complete_wr) begin
            pending_q <= 1'b0;
        end
    end

    assign mei_o = pending_q && enable_q;

    ////////////////////////////////////////
    // Read port
    ////////////////////////////////////////

    always_comb begin
        rd_word = '0;
        case (req_i.offset)
            `PE_PLIC_ENABLE:   rd_word[0] = enable_q;
            `PE_PLIC_PENDING:  rd_word[0] = pending_q;
            `PE_PLIC_COMPLETE: rd_word[0] = pending_q && enable_q;
            default: ;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rd_en) begin
            rdata_q <= rd_word;
        end
    end

    assign rdata_o = rdata_q;

endmodule

/* verilog/pe_core_link.sv */
`timescale 1ns/1ps

`include "pe_macros.svh"

module pe_core_link (
    input  logic                clk_i,
    input  logic                rst_ni,

    input  pe_pkg::bus_req_t    bus_req_i,

    output pe_pkg::periph_req_t rtc_req_o,
    output pe_pkg::periph_req_t plic_req_o,

    input  pe_pkg::word_t       rtc_rdata_i,
    input  pe_pkg::word_t       plic_rdata_i,
    input  pe_pkg::word_t       dmem_rdata_i,
    input  pe_pkg::word_t       ni_rdata_i,

    input  logic                mti_i,
    input  logic                mei_i,

    output logic                dmem_en_o,
    output logic                ni_en_o,

    output pe_pkg::word_t       cpu_rdata_o,
    output pe_pkg::irq_vec_t    irq_o
);

    import pe_pkg::*;

    periph_sel_t              sel;
    periph_sel_t              sel_q;
    logic [7:0]               region;
    logic                     any_we;
    logic [`PE_OFFSET_W-1:0]  offset;

    ////////////////////////////////////////
    // Region decode
    ////////////////////////////////////////

    assign region = bus_req_i.addr[`PE_REGION_MSB:`PE_REGION_LSB];
    assign offset = bus_req_i.addr[`PE_OFFSET_W-1:0];
    assign any_we = |bus_req_i.be;

    always_comb begin
        sel = '0;
        if (bus_req_i.en) begin
            sel.dmem = (region == `PE_REGION_DMEM);
            sel.rtc  = (region == `PE_REGION_RTC);
            sel.plic = (region == `PE_REGION_PLIC);
            sel.ni   = (region == `PE_REGION_NI);
        end
    end

    // Peripherals only see their own window
    assign rtc_req_o  = '{en: sel.rtc, we: any_we, offset: offset, wdata: bus_req_i.wdata};
    assign plic_req_o = '{en: sel.plic, we: any_we, offset: offset, wdata: bus_req_i.wdata};

    assign dmem_en_o = sel.dmem;
    assign ni_en_o   = sel.ni;

    ////////////////////////////////////////
    // Read return
    ////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            sel_q <= '0;
        end else begin
            sel_q <= sel;
        end
    end

    // Memory is also the fallback for unmapped reads
    always_comb begin
        if (sel_q.rtc)       cpu_rdata_o = rtc_rdata_i;
        else if (sel_q.plic) cpu_rdata_o = plic_rdata_i;
        else if (sel_q.ni)   cpu_rdata_o = ni_rdata_i;
        else                 cpu_rdata_o = dmem_rdata_i;
    end

    ////////////////////////////////////////
    // Interrupt vector
    ////////////////////////////////////////

    always_comb begin
        irq_o              = '0;
        irq_o[`PE_MTI_BIT] = mti_i;
        irq_o[`PE_MEI_BIT] = mei_i;
    end

endmodule

/* verilog/pe_periph_top.sv */
`timescale 1ns/1ps

module pe_periph_top (
    input  logic             clk_i,
    input  logic             rst_ni,

    input  pe_pkg::bus_req_t bus_req_i,
    output pe_pkg::word_t    cpu_rdata_o,

    output logic             dmem_en_o,
    input  pe_pkg::word_t    dmem_rdata_i,

    output logic             ni_en_o,
    input  pe_pkg::word_t    ni_rdata_i,
    input  logic             ni_irq_i,

    output pe_pkg::irq_vec_t irq_o,
    output pe_pkg::mtime_t   mtime_o
);

    import pe_pkg::*;

    periph_req_t rtc_req;
    periph_req_t plic_req;
    word_t       rtc_rdata;
    word_t       plic_rdata;
    logic        mti;
    logic        mei;

    ////////////////////////////////////////
    // Peripherals
    ////////////////////////////////////////

    pe_rtc rtc_m (
        .clk_i   (clk_i    ),
        .rst_ni  (rst_ni   ),
        .req_i   (rtc_req  ),
        .rdata_o (rtc_rdata),
        .mti_o   (mti      ),
        .mtime_o (mtime_o  )
    );

    pe_plic plic_m (
        .clk_i     (clk_i     ),
        .rst_ni    (rst_ni    ),
        .req_i     (plic_req  ),
        .irq_src_i (ni_irq_i  ),
        .rdata_o   (plic_rdata),
        .mei_o     (mei       )
    );

    ////////////////////////////////////////
    // Core side
    ////////////////////////////////////////

    pe_core_link link_m (
        .clk_i        (clk_i       ),
        .rst_ni       (rst_ni      ),
        .bus_req_i    (bus_req_i   ),
        .rtc_req_o    (rtc_req     ),
        .plic_req_o   (plic_req    ),
        .rtc_rdata_i  (rtc_rdata   ),
        .plic_rdata_i (plic_rdata  ),
        .dmem_rdata_i (dmem_rdata_i),
        .ni_rdata_i   (ni_rdata_i  ),
        .mti_i        (mti         ),
        .mei_i        (mei         ),
        .dmem_en_o    (dmem_en_o   ),
        .ni_en_o      (ni_en_o     ),
        .cpu_rdata_o  (cpu_rdata_o ),
        .irq_o        (irq_o       )
    );

endmodule

/* test/tb_pe_periph.sv */
`timescale 1ns/1ps

`include "pe_macros.svh"

module tb_pe_periph;

    import pe_pkg::*;

    localparam logic [2:0] CK_NONE     = 3'd0;
    localparam logic [2:0] CK_WORD     = 3'd1;
    localparam logic [2:0] CK_TIME     = 3'd2;
    localparam logic [2:0] CK_IRQ      = 3'd3;
    localparam logic [2:0] CK_WAIT_MTI = 3'd4;

    // One table row
    // The rel flag adds the current mtime to the write data
    typedef struct packed {
        bus_req_t   req;
        logic       irq;
        logic       rel;
        logic [2:0] kind;
        word_t      exp;
    } entry_t;

    logic     clk_i;
    logic     rst_ni;
    bus_req_t bus_req_i;
    word_t    cpu_rdata_o;
    logic     dmem_en_o;
    word_t    dmem_rdata_i;
    logic     ni_en_o;
    word_t    ni_rdata_i;
    logic     ni_irq_i;
    irq_vec_t irq_o;
    mtime_t   mtime_o;

    entry_t   table_q[$];
    int       errors = 0;
    int       checks = 0;
    int       cycle_count = 0;
    int       cycle_limit = 200;

    pe_periph_top UUT (
        .clk_i        (clk_i       ),
        .rst_ni       (rst_ni      ),
        .bus_req_i    (bus_req_i   ),
        .cpu_rdata_o  (cpu_rdata_o ),
        .dmem_en_o    (dmem_en_o   ),
        .dmem_rdata_i (dmem_rdata_i),
        .ni_en_o      (ni_en_o     ),
        .ni_rdata_i   (ni_rdata_i  ),
        .ni_irq_i     (ni_irq_i    ),
        .irq_o        (irq_o       ),
        .mtime_o      (mtime_o     )
    );

    always #2 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("run stopped after %0d cycles without finishing", cycle_count);
            $display("sim failed");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Compare tasks and helpers
    ////////////////////////////////////////

    task automatic compare_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic compare_irq(input string name, input irq_vec_t got, input irq_vec_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic compare_mtime(input string name, input mtime_t got, input mtime_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic wait_for_mti();
        int n;
        n = 0;
        while (irq_o[`PE_MTI_BIT] !== 1'b1 && n < 64) begin
            @(negedge clk_i);
            n++;
        end
        checks++;
        if (irq_o[`PE_MTI_BIT] !== 1'b1) begin
            errors++;
            $display("timer interrupt did not rise within 64 cycles");
        end
    endtask

    function automatic bus_req_t make_req(input logic en, input logic [3:0] be,
            input logic [7:0] region, input logic [23:0] offset, input word_t wdata);
        bus_req_t r;
        r.en    = en;
        r.be    = be;
        r.addr  = {region, offset};
        r.wdata = wdata;
        return r;
    endfunction

    task automatic add_entry(input bus_req_t req, input logic irq, input logic rel,
            input logic [2:0] kind, input word_t exp);
        entry_t e;
        e.req  = req;
        e.irq  = irq;
        e.rel  = rel;
        e.kind = kind;
        e.exp  = exp;
        table_q.push_back(e);
    endtask

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    initial begin
        entry_t e;
        mtime_t req_mtime;
        word_t  wr_a;
        word_t  wr_b;
        void'($urandom(32'hbefc));
        clk_i        = 1'b0;
        rst_ni       = 1'b0;
        bus_req_i    = '0;
        ni_irq_i     = 1'b0;
        dmem_rdata_i = $urandom;
        ni_rdata_i   = $urandom;
        wr_a         = $urandom;
        wr_b         = $urandom;

        // Region decode
        add_entry(make_req(1, 4'h0, `PE_REGION_DMEM, 24'h10, 0), 0, 0, CK_WORD, dmem_rdata_i);
        add_entry(make_req(1, 4'hF, `PE_REGION_DMEM, 24'h14, wr_a), 0, 0, CK_NONE, 0);
        add_entry(make_req(1, 4'h0, `PE_REGION_NI, 24'h20, 0), 0, 0, CK_WORD, ni_rdata_i);
        add_entry(make_req(1, 4'h0, 8'h10, 24'h30, 0), 0, 0, CK_WORD, dmem_rdata_i);
        add_entry(make_req(0, 4'h0, `PE_REGION_DMEM, 24'h10, 0), 0, 0, CK_NONE, 0);
        // Clock reads and compare register
        add_entry(make_req(1, 4'h0, `PE_REGION_RTC, `PE_RTC_MTIME_LO, 0), 0, 0, CK_TIME, 0);
        add_entry(make_req(1, 4'h0, `PE_REGION_RTC, `PE_RTC_MTIME_HI, 0), 0, 0, CK_WORD, 0);
        add_entry(make_req(1, 4'hF, `PE_REGION_RTC, `PE_RTC_CMP_HI, '1), 0, 0, CK_NONE, 0);
        add_entry(make_req(1, 4'hF, `PE_REGION_RTC, `PE_RTC_CMP_LO, wr_b), 0, 0, CK_NONE, 0);
        add_entry(make_req(1, 4'h0, `PE_REGION_RTC, `PE_RTC_CMP_HI, 0), 0, 0, CK_WORD, '1);
        add_entry(make_req(1, 4'h0, `PE_REGION_RTC, `PE_RTC_CMP_LO, 0), 0, 0, CK_WORD, wr_b);
        add_entry(make_req(0, 4'h0, 8'h00, 24'h0, 0), 0, 0, CK_IRQ, 0);
        // Timer interrupt a few cycles ahead, then silenced again
        add_entry(make_req(1, 4'hF, `PE_REGION_RTC, `PE_RTC_CMP_LO, 20), 0, 1, CK_NONE, 0);
        add_entry(make_req(1, 4'hF, `PE_REGION_RTC, `PE_RTC_CMP_HI, 0), 0, 0, CK_WAIT_MTI, 0);
        add_entry(make_req(1, 4'hF, `PE_REGION_RTC, `PE_RTC_CMP_HI, '1), 0, 0, CK_IRQ, 0);
        // Interrupt controller
        add_entry(make_req(1, 4'hF, `PE_REGION_PLIC, `PE_PLIC_ENABLE, 1), 0, 0, CK_NONE, 0);
        add_entry(make_req(0, 4'h0, 8'h00, 24'h0, 0), 1, 0, CK_IRQ, 32'h1 << `PE_MEI_BIT);
        add_entry(make_req(1, 4'h0, `PE_REGION_PLIC, `PE_PLIC_PENDING, 0), 1, 0, CK_WORD, 1);
        add_entry(make_req(0, 4'h0, 8'h00, 24'h0, 0), 0, 0, CK_IRQ, 32'h1 << `PE_MEI_BIT);
        add_entry(make_req(1, 4'hF, `PE_REGION_PLIC, `PE_PLIC_COMPLETE, 0), 0, 0, CK_IRQ, 0);
        add_entry(make_req(1, 4'h0, `PE_REGION_PLIC, `PE_PLIC_PENDING, 0), 0, 0, CK_WORD, 0);
        add_entry(make_req(1, 4'hF, `PE_REGION_PLIC, `PE_PLIC_ENABLE, 0), 0, 0, CK_NONE, 0);
        add_entry(make_req(0, 4'h0, 8'h00, 24'h0, 0), 1, 0, CK_IRQ, 0);
        add_entry(make_req(1, 4'h0, `PE_REGION_PLIC, `PE_PLIC_PENDING, 0), 1, 0, CK_WORD, 1);
        add_entry(make_req(1, 4'h0, `PE_REGION_PLIC, `PE_PLIC_COMPLETE, 0), 1, 0, CK_WORD, 0);

        cycle_limit = 8 * table_q.size() + 200;

        repeat (5) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(negedge clk_i);

        foreach (table_q[i]) begin
            e = table_q[i];
            if (e.rel) begin
                e.req.wdata = mtime_o[31:0] + e.req.wdata;
            end
            @(posedge clk_i);
            bus_req_i <= e.req;
            ni_irq_i  <= e.irq;
            @(negedge clk_i);
            req_mtime = mtime_o;
            compare_bit("dmem_en_o", dmem_en_o,
                e.req.en && (e.req.addr[31:24] == `PE_REGION_DMEM));
            compare_bit("ni_en_o", ni_en_o,
                e.req.en && (e.req.addr[31:24] == `PE_REGION_NI));
            @(posedge clk_i);
            bus_req_i <= '0;
            @(negedge clk_i);
            compare_mtime("mtime_o", mtime_o, req_mtime + 64'd1);
            case (e.kind)
                CK_WORD:     compare_word("cpu_rdata_o", cpu_rdata_o, e.exp);
                CK_TIME:     compare_word("cpu_rdata_o", cpu_rdata_o, req_mtime[31:0]);
                CK_IRQ:      compare_irq("irq_o", irq_o, e.exp);
                CK_WAIT_MTI: wait_for_mti();
                default: ;
            endcase
        end

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* compile.f */
+incdir+include
verilog/pe_pkg.sv
verilog/pe_rtc.sv
verilog/pe_plic.sv
verilog/pe_core_link.sv
verilog/pe_periph_top.sv
test/tb_pe_periph.sv

/* Makefile */
TOOL  = verilator
FLAGS = --binary --timing -Wno-fatal
TOP   = tb_pe_periph
FLIST = compile.f
OBJ   = obj_dir
LOG   = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: build
	./$(OBJ)/V$(TOP) | tee $(LOG)
	@grep -q "^sim passed" $(LOG)

lint:
	$(TOOL) --lint-only --timing -Wall --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ) $(LOG)
